// ==== axi_mem_model.sv ====
// **************************************************************************
// testbench AXI subordinate, byte memory with strobes and random stalls
// **************************************************************************

`timescale 1ns/100ps

module axi_mem_model (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // 0 random stalls, 1 W held back, 2 AW held back, 3 no stalls
  input  logic [1:0]                      mode_i,
  input  fifo_axi_pkg::axi_ax_t           axi_aw_i,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  fifo_axi_pkg::axi_w_t            axi_w_i,
  input  logic                            wvalid_i,
  output logic                            wready_o,
  output logic                            bvalid_o,
  input  logic                            bready_i,
  input  fifo_axi_pkg::axi_ax_t           axi_ar_i,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  output logic [fifo_axi_pkg::DATA_W-1:0] rdata_o,
  output logic                            rvalid_o,
  input  logic                            rready_i
);

  import fifo_axi_pkg::*;

  logic [7:0]        mem [64];
  axi_ax_t           aw_q [$];
  axi_w_t            w_q [$];
  logic [DATA_W-1:0] r_q [$];
  int                b_cnt;
  logic              b_fire;
  logic              r_fire;
  logic [31:0]       seed;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // true with a chance of n in 16
  function automatic logic take_chance(input int n);
    seed = lcg_next(seed);
    return int'(seed[19:16]) < n;
  endfunction

  function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] word;
    for (int lane = 0; lane < MASK_W; lane++) begin
      word[lane*8 +: 8] = mem[{addr[5:3], 3'(lane)}];
    end
    return word;
  endfunction

  task automatic apply_write(input axi_ax_t aw, input axi_w_t w);
    for (int lane = 0; lane < MASK_W; lane++) begin
      if (w.strb[lane]) begin
        mem[{aw.addr[5:3], 3'(lane)}] = w.data[lane*8 +: 8];
      end
    end
  endtask

  initial begin
    seed = 32'h953a9209;
    for (int i = 0; i < 64; i++) begin
      mem[i] = 8'(i * 29 + 53);
    end
    awready_o = 1'b0;
    wready_o  = 1'b0;
    arready_o = 1'b0;
    bvalid_o  = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    b_cnt     = 0;
    b_fire    = 1'b0;
    r_fire    = 1'b0;
  end

  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      awready_o = 1'b0;
      wready_o  = 1'b0;
      arready_o = 1'b0;
      bvalid_o  = 1'b0;
      rvalid_o  = 1'b0;
      b_fire    = 1'b0;
      r_fire    = 1'b0;
      b_cnt     = 0;
      aw_q.delete();
      w_q.delete();
      r_q.delete();
    end else begin
      // retire beats taken at the rising edge just past
      if (b_fire) begin
        bvalid_o = 1'b0;
        b_cnt--;
      end
      if (r_fire) begin
        rvalid_o = 1'b0;
        r_q.delete(0);
      end
      // responses after a random delay, held until taken
      if (!bvalid_o && b_cnt > 0) begin
        bvalid_o = take_chance(6);
      end
      if (!rvalid_o && r_q.size() > 0 && take_chance(6)) begin
        rvalid_o = 1'b1;
        rdata_o  = r_q[0];
      end
      b_fire = bvalid_o & bready_i;
      r_fire = rvalid_o & rready_i;
      case (mode_i)
        2'd0: begin
          awready_o = take_chance(9);
          wready_o  = take_chance(9);
          arready_o = take_chance(9);
        end
        2'd1: begin
          awready_o = 1'b1;
          wready_o  = take_chance(3);
          arready_o = 1'b1;
        end
        2'd2: begin
          awready_o = take_chance(3);
          wready_o  = 1'b1;
          arready_o = 1'b1;
        end
        default: begin
          awready_o = 1'b1;
          wready_o  = 1'b1;
          arready_o = 1'b1;
        end
      endcase
      // these handshakes complete at the next rising edge
      if (awvalid_i && awready_o) aw_q.push_back(axi_aw_i);
      if (wvalid_i && wready_o) w_q.push_back(axi_w_i);
      if (arvalid_i && arready_o) r_q.push_back(read_word(axi_ar_i.addr));
      while (aw_q.size() > 0 && w_q.size() > 0) begin
        apply_write(aw_q.pop_front(), w_q.pop_front());
        b_cnt++;
      end
    end
  end

endmodule

// ==== fifo_axi_pkg.sv ====
// **************************************************************************
// shared widths, FIFO depths, AXI size encoding and payload structs
// **************************************************************************

package fifo_axi_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int MASK_W = DATA_W / 8;

  // buffer depths
  localparam int RD_REQ_ELS  = 2;
  localparam int WR_REQ_ELS  = 2;
  localparam int RD_RESP_ELS = 2;
  localparam int WR_RESP_ELS = 2;
  // one slot for every request that can be outstanding in the request FIFOs
  localparam int ORDER_ELS   = RD_REQ_ELS + WR_REQ_ELS;

  // AxSIZE encoding, bytes per beat
  typedef enum logic [2:0] {
    SIZE_1B = 3'd0,
    SIZE_2B = 3'd1,
    SIZE_4B = 3'd2,
    SIZE_8B = 3'd3
  } axi_size_e;

  // request as offered by the requester
  typedef struct packed {
    logic              w;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] wmask;
    axi_size_e         size;
  } fifo_req_t;

  // response handed back in request order
  typedef struct packed {
    logic              w;
    logic [DATA_W-1:0] data;
  } fifo_resp_t;

  // queued read, waiting for AR
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    axi_size_e         size;
  } rd_req_t;

  // queued write, waiting for AW and W
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] wmask;
    axi_size_e         size;
  } wr_req_t;

  // AW / AR address payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    axi_size_e         size;
  } axi_ax_t;

  // W payload
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] strb;
  } axi_w_t;

endpackage

// ==== fifo_to_axi_top.sv ====
// **************************************************************************
// valid/ready request FIFO to single-beat AXI4 manager bridge, top level
// **************************************************************************

`timescale 1ns/100ps

module fifo_to_axi_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // request side
  input  fifo_axi_pkg::fifo_req_t         req_i,
  input  logic                            req_v_i,
  output logic                            req_ready_and_o,
  // response side
  output fifo_axi_pkg::fifo_resp_t        resp_o,
  output logic                            resp_v_o,
  input  logic                            resp_yumi_i,
  // AXI write address and data
  output fifo_axi_pkg::axi_ax_t           axi_aw_o,
  output logic                            awvalid_o,
  input  logic                            awready_i,
  output fifo_axi_pkg::axi_w_t            axi_w_o,
  output logic                            wvalid_o,
  input  logic                            wready_i,
  // AXI write response
  input  logic                            bvalid_i,
  output logic                            bready_o,
  // AXI read address and data
  output fifo_axi_pkg::axi_ax_t           axi_ar_o,
  output logic                            arvalid_o,
  input  logic                            arready_i,
  input  logic [fifo_axi_pkg::DATA_W-1:0] axi_rdata_i,
  input  logic                            rvalid_i,
  output logic                            rready_o
);

  import fifo_axi_pkg::*;

  rd_req_t rd_req;
  logic    rd_v;
  logic    rd_yumi;
  wr_req_t wr_req;
  logic    wr_v;
  logic    wr_yumi;
  logic    order_v;
  logic    order_w;
  logic    order_ready;

  req_split split0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .req_i(req_i), .req_v_i(req_v_i), .req_ready_and_o(req_ready_and_o),
    .rd_req_o(rd_req), .rd_v_o(rd_v), .rd_yumi_i(rd_yumi),
    .wr_req_o(wr_req), .wr_v_o(wr_v), .wr_yumi_i(wr_yumi),
    .order_v_o(order_v), .order_w_o(order_w), .order_ready_i(order_ready)
  );

  // AR straight from the read FIFO head, popped on acceptance
  assign axi_ar_o.addr = rd_req.addr;
  assign axi_ar_o.size = rd_req.size;
  assign arvalid_o     = rd_v;
  assign rd_yumi       = arvalid_o & arready_i;

  wr_issue_fsm wr_fsm0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .wr_req_i(wr_req), .wr_v_i(wr_v), .awready_i(awready_i), .wready_i(wready_i),
    .wr_yumi_o(wr_yumi), .axi_aw_o(axi_aw_o), .awvalid_o(awvalid_o),
    .axi_w_o(axi_w_o), .wvalid_o(wvalid_o)
  );

  resp_reorder reorder0 (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .order_v_i(order_v), .order_w_i(order_w), .order_ready_o(order_ready),
    .bvalid_i(bvalid_i), .bready_o(bready_o),
    .rvalid_i(rvalid_i), .rdata_i(axi_rdata_i), .rready_o(rready_o),
    .resp_o(resp_o), .resp_v_o(resp_v_o), .resp_yumi_i(resp_yumi_i)
  );

endmodule

// ==== files.f ====
fifo_axi_pkg.sv
small_fifo.sv
req_split.sv
wr_issue_fsm.sv
resp_reorder.sv
fifo_to_axi_top.sv
axi_mem_model.sv
tb_fifo_to_axi.sv

// ==== req_split.sv ====
// **************************************************************************
// request splitter into read and write request FIFOs plus order queue push
// **************************************************************************

`timescale 1ns/100ps

module req_split (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  fifo_axi_pkg::fifo_req_t req_i,
  input  logic                    req_v_i,
  output logic                    req_ready_and_o,
  output fifo_axi_pkg::rd_req_t   rd_req_o,
  output logic                    rd_v_o,
  input  logic                    rd_yumi_i,
  output fifo_axi_pkg::wr_req_t   wr_req_o,
  output logic                    wr_v_o,
  input  logic                    wr_yumi_i,
  output logic                    order_v_o,
  output logic                    order_w_o,
  input  logic                    order_ready_i
);

  import fifo_axi_pkg::*;

  rd_req_t rd_in;
  wr_req_t wr_in;
  logic    rd_ready;
  logic    wr_ready;
  logic    rd_push;
  logic    wr_push;

  // a request goes in only when the order queue and both request FIFOs have room
  assign req_ready_and_o = rd_ready & wr_ready & order_ready_i;

  assign rd_push   = req_v_i & ~req_i.w & rd_ready & wr_ready & order_ready_i;
  assign wr_push   = req_v_i &  req_i.w & rd_ready & wr_ready & order_ready_i;
  // order queue sees its own ready, so leave it out of its valid
  assign order_v_o = req_v_i & rd_ready & wr_ready;
  assign order_w_o = req_i.w;

  always_comb begin
    rd_in.addr  = req_i.addr;
    rd_in.size  = req_i.size;
    wr_in.addr  = req_i.addr;
    wr_in.data  = req_i.data;
    wr_in.wmask = req_i.wmask;
    wr_in.size  = req_i.size;
  end

  small_fifo #(
    .width_p ($bits(rd_req_t)),
    .els_p   (RD_REQ_ELS)
  ) rd_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (rd_push),
    .data_i      (rd_in),
    .ready_and_o (rd_ready),
    .v_o         (rd_v_o),
    .data_o      (rd_req_o),
    .yumi_i      (rd_yumi_i)
  );

  small_fifo #(
    .width_p ($bits(wr_req_t)),
    .els_p   (WR_REQ_ELS)
  ) wr_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (wr_push),
    .data_i      (wr_in),
    .ready_and_o (wr_ready),
    .v_o         (wr_v_o),
    .data_o      (wr_req_o),
    .yumi_i      (wr_yumi_i)
  );

  // an accepted read is waiting at the read FIFO head one cycle later
  a_rd_visible: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_push |=> rd_v_o);

  // same for an accepted write at the write FIFO head
  a_wr_visible: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wr_push |=> wr_v_o);

endmodule

// ==== resp_reorder.sv ====
// **************************************************************************
// B and R response FIFOs, order queue and in-order response selection
// **************************************************************************

`timescale 1ns/100ps

module resp_reorder (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              order_v_i,
  input  logic                              order_w_i,
  output logic                              order_ready_o,
  input  logic                              bvalid_i,
  output logic                              bready_o,
  input  logic                              rvalid_i,
  input  logic [fifo_axi_pkg::DATA_W-1:0]   rdata_i,
  output logic                              rready_o,
  output fifo_axi_pkg::fifo_resp_t          resp_o,
  output logic                              resp_v_o,
  input  logic                              resp_yumi_i
);

  import fifo_axi_pkg::*;

  logic              ord_v;
  logic              ord_w;
  logic              ord_yumi;
  logic              b_v;
  logic              b_yumi;
  logic              r_v;
  logic              r_yumi;
  logic [DATA_W-1:0] r_data;

  // kind of each outstanding request, oldest at the head
  small_fifo #(
    .width_p (1),
    .els_p   (ORDER_ELS)
  ) order_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (order_v_i),
    .data_i      (order_w_i),
    .ready_and_o (order_ready_o),
    .v_o         (ord_v),
    .data_o      (ord_w),
    .yumi_i      (ord_yumi)
  );

  // B beats carry no payload, only their arrival counts
  small_fifo #(
    .width_p (1),
    .els_p   (WR_RESP_ELS)
  ) b_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (bvalid_i),
    .data_i      (1'b1),
    .ready_and_o (bready_o),
    .v_o         (b_v),
    .data_o      (),
    .yumi_i      (b_yumi)
  );

  small_fifo #(
    .width_p (DATA_W),
    .els_p   (RD_RESP_ELS)
  ) r_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .v_i         (rvalid_i),
    .data_i      (rdata_i),
    .ready_and_o (rready_o),
    .v_o         (r_v),
    .data_o      (r_data),
    .yumi_i      (r_yumi)
  );

  // head kind picks which response FIFO must be non-empty
  assign resp_v_o = ord_v & (ord_w ? b_v : r_v);

  always_comb begin
    resp_o.w    = ord_w;
    resp_o.data = ord_w ? {DATA_W{1'b0}} : r_data;
  end

  assign ord_yumi = resp_yumi_i;
  assign b_yumi   = resp_yumi_i & ord_w;
  assign r_yumi   = resp_yumi_i & ~ord_w;

  a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_yumi_i |-> resp_v_o);

  // an offered response waits unchanged for the requester
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_v_o && !resp_yumi_i |=> resp_v_o && $stable(resp_o));

endmodule

// ==== small_fifo.sv ====
// **************************************************************************
// small register FIFO, valid/ready_and in and valid/yumi out
// **************************************************************************

`timescale 1ns/100ps

module small_fifo #(
  parameter int width_p = 8,
  parameter int els_p   = 2
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_and_o,
  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam logic [ptr_w_lp-1:0] last_ptr_lp = ptr_w_lp'(els_p - 1);

  logic [width_p-1:0]  mem_r [els_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  // set by a push, cleared by a pop, tells full from empty
  logic                last_push_r;
  logic                ptr_eq;
  logic                full;
  logic                empty;
  logic                push;
  logic                pop;

  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    logic [ptr_w_lp-1:0] nxt;
    nxt = (ptr == last_ptr_lp) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign ptr_eq      = (wr_ptr_r == rd_ptr_r);
  assign full        = ptr_eq & last_push_r;
  assign empty       = ptr_eq & ~last_push_r;
  assign ready_and_o = ~full;
  assign v_o         = ~empty;
  assign push        = v_i & ~full;
  assign pop         = yumi_i;
  assign data_o      = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r    <= '0;
      rd_ptr_r    <= '0;
      last_push_r <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      // a push and a pop together leave the fill level unchanged
      if (push != pop) begin
        last_push_r <= push;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // the consumer only pops what it was shown
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    yumi_i |-> v_o);

endmodule

// ==== tb_fifo_to_axi.sv ====
// **************************************************************************
// testbench top, clock and reset, directed tests, expected model, watchdog
// **************************************************************************

`timescale 1ns/100ps

module tb_fifo_to_axi;

  import fifo_axi_pkg::*;

  // 2 + 3 + 8 + 40 + at most 8 in the back-pressure test
  localparam int total_reqs_lp  = 61;
  localparam int watchdog_ns_lp = total_reqs_lp * 200 * 10;
  localparam logic [ADDR_W-1:0] base_addr_lp = 32'h0000_2000;

  logic              clk;
  logic              arst_n;
  fifo_req_t         req;
  logic              req_v;
  logic              req_ready;
  fifo_resp_t        resp;
  logic              resp_v;
  logic              resp_yumi;
  axi_ax_t           axi_aw;
  axi_ax_t           axi_ar;
  axi_w_t            axi_w;
  logic              awvalid;
  logic              awready;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;
  logic              arvalid;
  logic              arready;
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        mem_mode;

  int          errors;
  int          checks;
  int          tests;
  logic [7:0]  exp_mem [64];
  fifo_resp_t  exp_q [$];
  int          exp_idx_q [$];
  axi_ax_t     exp_aw_q [$];
  axi_ax_t     exp_ar_q [$];
  axi_w_t      exp_w_q [$];
  int          wr_pend [8];
  int          rd_pend [8];
  logic        yumi_hold;
  logic        yumi_rand;
  logic [31:0] drv_seed;
  logic [31:0] col_seed;
  logic        done_w;
  int          done_idx;

  fifo_to_axi_top dut0 (
    .clk_i(clk), .arst_n_i(arst_n),
    .req_i(req), .req_v_i(req_v), .req_ready_and_o(req_ready),
    .resp_o(resp), .resp_v_o(resp_v), .resp_yumi_i(resp_yumi),
    .axi_aw_o(axi_aw), .awvalid_o(awvalid), .awready_i(awready),
    .axi_w_o(axi_w), .wvalid_o(wvalid), .wready_i(wready),
    .bvalid_i(bvalid), .bready_o(bready),
    .axi_ar_o(axi_ar), .arvalid_o(arvalid), .arready_i(arready),
    .axi_rdata_i(rdata), .rvalid_i(rvalid), .rready_o(rready)
  );

  axi_mem_model mem0 (
    .clk_i(clk), .arst_n_i(arst_n), .mode_i(mem_mode),
    .axi_aw_i(axi_aw), .awvalid_i(awvalid), .awready_o(awready),
    .axi_w_i(axi_w), .wvalid_i(wvalid), .wready_o(wready),
    .bvalid_o(bvalid), .bready_i(bready),
    .axi_ar_i(axi_ar), .arvalid_i(arvalid), .arready_o(arready),
    .rdata_o(rdata), .rvalid_o(rvalid), .rready_i(rready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(watchdog_ns_lp);
    $display("watchdog expired before the tests completed");
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    drv_seed = lcg_next(drv_seed);
    rand_word[63:32] = drv_seed;
    drv_seed = lcg_next(drv_seed);
    rand_word[31:0] = drv_seed;
  endfunction

  // aligned 8-byte word of the expected memory
  function automatic logic [DATA_W-1:0] word_at(input int idx);
    logic [DATA_W-1:0] word;
    for (int lane = 0; lane < MASK_W; lane++) begin
      word[lane*8 +: 8] = exp_mem[idx*8 + lane];
    end
    return word;
  endfunction

  function automatic fifo_req_t make_req(input logic w, input int idx,
                                         input logic [DATA_W-1:0] data,
                                         input logic [MASK_W-1:0] mask);
    fifo_req_t r;
    r.w     = w;
    r.addr  = base_addr_lp + ADDR_W'(idx * 8);
    r.data  = data;
    r.wmask = mask;
    r.size  = SIZE_8B;
    return r;
  endfunction

  // AR and AW are unordered, so hold off a request that touches a word
  // with an outstanding access of the other kind
  function automatic logic blocked_by_pending(input fifo_req_t r);
    return r.w ? (rd_pend[r.addr[5:3]] != 0) : (wr_pend[r.addr[5:3]] != 0);
  endfunction

  task automatic check_resp(input string name, input fifo_resp_t got, input fifo_resp_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_ax(input string name, input axi_ax_t got, input axi_ax_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_w(input string name, input axi_w_t got, input axi_w_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  // called and returns at a falling edge
  task automatic send_req(input fifo_req_t r);
    int         idx;
    fifo_resp_t e;
    axi_ax_t    ax;
    axi_w_t     wd;
    idx = r.addr[5:3];
    while (blocked_by_pending(r)) @(negedge clk);
    req   = r;
    req_v = 1'b1;
    while (!req_ready) @(negedge clk);
    // taken at the coming rising edge
    e.w     = r.w;
    e.data  = '0;
    ax.addr = r.addr;
    ax.size = r.size;
    wd.data = r.data;
    wd.strb = r.wmask;
    if (r.w) begin
      for (int lane = 0; lane < MASK_W; lane++) begin
        if (r.wmask[lane]) exp_mem[idx*8 + lane] = r.data[lane*8 +: 8];
      end
      wr_pend[idx]++;
      exp_aw_q.push_back(ax);
      exp_w_q.push_back(wd);
    end else begin
      e.data = word_at(idx);
      rd_pend[idx]++;
      exp_ar_q.push_back(ax);
    end
    exp_q.push_back(e);
    exp_idx_q.push_back(idx);
    @(negedge clk);
    req_v = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() > 0) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests++;
    $display("%-18s %s", name, (errors == errs_at_start) ? "ok" : "mismatches seen");
  endtask

  // requester side, consumes responses and compares them in order
  always @(negedge clk) begin
    resp_yumi = 1'b0;
    if (arst_n && resp_v && !yumi_hold) begin
      col_seed = lcg_next(col_seed);
      if (!yumi_rand || col_seed[17]) begin
        done_idx = -1;
        if (exp_q.size() == 0) begin
          errors++;
          $display("response offered with no request outstanding");
        end else begin
          check_resp("resp_o", resp, exp_q[0]);
          done_w   = exp_q[0].w;
          done_idx = exp_idx_q[0];
          exp_q.delete(0);
          exp_idx_q.delete(0);
        end
        resp_yumi = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (resp_yumi && done_idx >= 0) begin
      if (done_w) wr_pend[done_idx]--;
      else rd_pend[done_idx]--;
    end
  end

  // AXI beats against the requests that produced them, in issue order
  always @(posedge clk) begin
    if (arst_n && awvalid && awready) begin
      if (exp_aw_q.size() == 0) begin
        errors++;
        $display("AW beat accepted with no write outstanding");
      end else begin
        check_ax("axi_aw_o", axi_aw, exp_aw_q.pop_front());
      end
    end
    if (arst_n && wvalid && wready) begin
      if (exp_w_q.size() == 0) begin
        errors++;
        $display("W beat accepted with no write outstanding");
      end else begin
        check_w("axi_w_o", axi_w, exp_w_q.pop_front());
      end
    end
    if (arst_n && arvalid && arready) begin
      if (exp_ar_q.size() == 0) begin
        errors++;
        $display("AR beat accepted with no read outstanding");
      end else begin
        check_ax("axi_ar_o", axi_ar, exp_ar_q.pop_front());
      end
    end
  end

  task automatic test_reset();
    int e0;
    e0 = errors;
    check_bit("awvalid_o", awvalid, 1'b0);
    check_bit("wvalid_o", wvalid, 1'b0);
    check_bit("arvalid_o", arvalid, 1'b0);
    check_bit("resp_v_o", resp_v, 1'b0);
    check_bit("req_ready_and_o", req_ready, 1'b1);
    check_bit("bready_o", bready, 1'b1);
    check_bit("rready_o", rready, 1'b1);
    report_test("test_reset", e0);
  endtask

  task automatic test_write_read();
    int e0;
    e0 = errors;
    mem_mode = 2'd3;
    send_req(make_req(1'b1, 0, 64'h0123_4567_89ab_cdef, 8'hff));
    send_req(make_req(1'b0, 0, '0, '0));
    wait_drain();
    report_test("test_write_read", e0);
  endtask

  task automatic test_strobe();
    int e0;
    e0 = errors;
    send_req(make_req(1'b1, 1, 64'h1111_2222_3333_4444, 8'h0f));
    send_req(make_req(1'b1, 1, 64'hffee_ddcc_bbaa_9988, 8'hf0));
    send_req(make_req(1'b0, 1, '0, '0));
    wait_drain();
    report_test("test_strobe", e0);
  endtask

  task automatic test_split_aw_w();
    int e0;
    e0 = errors;
    // AW taken first, W later
    mem_mode = 2'd1;
    send_req(make_req(1'b1, 2, rand_word(), 8'hff));
    send_req(make_req(1'b1, 3, rand_word(), 8'h3c));
    wait_drain();
    // and the reverse
    mem_mode = 2'd2;
    send_req(make_req(1'b1, 4, rand_word(), 8'hff));
    send_req(make_req(1'b1, 5, rand_word(), 8'ha5));
    wait_drain();
    mem_mode = 2'd0;
    for (int idx = 2; idx < 6; idx++) begin
      send_req(make_req(1'b0, idx, '0, '0));
    end
    wait_drain();
    report_test("test_split_aw_w", e0);
  endtask

  task automatic test_mixed_random();
    int          e0;
    logic [31:0] pick;
    e0 = errors;
    mem_mode  = 2'd0;
    yumi_rand = 1'b1;
    for (int n = 0; n < 40; n++) begin
      drv_seed = lcg_next(drv_seed);
      pick = drv_seed;
      send_req(make_req(pick[20], int'(pick[23:21]), rand_word(), pick[31:24]));
    end
    wait_drain();
    yumi_rand = 1'b0;
    report_test("test_mixed_random", e0);
  endtask

  task automatic test_backpressure();
    int         e0;
    int         k;
    fifo_resp_t held;
    e0 = errors;
    mem_mode  = 2'd3;
    yumi_hold = 1'b1;
    k = 0;
    // writes and reads on separate words until the bridge fills up
    while (req_ready && k < 8) begin
      send_req(make_req((k % 2) == 0, k, rand_word(), 8'hff));
      k++;
    end
    check_bit("req_ready_and_o", req_ready, 1'b0);
    while (!resp_v) @(negedge clk);
    held = resp;
    repeat (10) begin
      @(negedge clk);
      check_bit("resp_v_o", resp_v, 1'b1);
      check_resp("resp_o", resp, held);
    end
    yumi_hold = 1'b0;
    wait_drain();
    report_test("test_backpressure", e0);
  endtask

  initial begin
    errors    = 0;
    checks    = 0;
    tests     = 0;
    arst_n    = 1'b0;
    req       = '0;
    req_v     = 1'b0;
    resp_yumi = 1'b0;
    mem_mode  = 2'd3;
    yumi_hold = 1'b0;
    yumi_rand = 1'b0;
    drv_seed  = 32'h953a9209;
    col_seed  = lcg_next(32'h953a9209);
    done_w    = 1'b0;
    done_idx  = -1;
    for (int i = 0; i < 64; i++) begin
      exp_mem[i] = 8'(i * 29 + 53);
    end
    for (int i = 0; i < 8; i++) begin
      wr_pend[i] = 0;
      rd_pend[i] = 0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    test_reset();
    test_write_read();
    test_strobe();
    test_split_aw_w();
    test_mixed_random();
    test_backpressure();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== wr_issue_fsm.sv ====
// **************************************************************************
// AW and W issue state machine for the head write request
// **************************************************************************

`timescale 1ns/100ps

module wr_issue_fsm (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  fifo_axi_pkg::wr_req_t wr_req_i,
  input  logic                  wr_v_i,
  input  logic                  awready_i,
  input  logic                  wready_i,
  output logic                  wr_yumi_o,
  output fifo_axi_pkg::axi_ax_t axi_aw_o,
  output logic                  awvalid_o,
  output fifo_axi_pkg::axi_w_t  axi_w_o,
  output logic                  wvalid_o
);

  import fifo_axi_pkg::*;

  // which half of the head write the subordinate already holds
  typedef enum logic [1:0] {
    IDLE_BOTH = 2'd0,
    AW_DONE   = 2'd1,
    W_DONE    = 2'd2
  } state_e;

  state_e state_r;
  state_e state_n;
  logic   aw_fire;
  logic   w_fire;

  always_comb begin
    axi_aw_o.addr = wr_req_i.addr;
    axi_aw_o.size = wr_req_i.size;
    axi_w_o.data  = wr_req_i.data;
    axi_w_o.strb  = wr_req_i.wmask;
  end

  // drive only the channel that is still owed
  assign awvalid_o = wr_v_i & (state_r != AW_DONE);
  assign wvalid_o  = wr_v_i & (state_r != W_DONE);
  assign aw_fire   = awvalid_o & awready_i;
  assign w_fire    = wvalid_o & wready_i;

  always_comb begin
    state_n   = state_r;
    wr_yumi_o = 1'b0;
    case (state_r)
      IDLE_BOTH: begin
        if (aw_fire && w_fire) begin
          wr_yumi_o = 1'b1;
        end else if (aw_fire) begin
          state_n = AW_DONE;
        end else if (w_fire) begin
          state_n = W_DONE;
        end
      end
      AW_DONE: begin
        if (w_fire) begin
          wr_yumi_o = 1'b1;
          state_n   = IDLE_BOTH;
        end
      end
      W_DONE: begin
        if (aw_fire) begin
          wr_yumi_o = 1'b1;
          state_n   = IDLE_BOTH;
        end
      end
      default: state_n = IDLE_BOTH;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_r <= IDLE_BOTH;
    end else begin
      state_r <= state_n;
    end
  end

  // AXI rule, a raised awvalid holds with a steady payload until taken
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    awvalid_o && !awready_i |=> awvalid_o && $stable(axi_aw_o));

endmodule
